//--- Makefile
VERILATOR ?= verilator
TOP ?= cache_tb
BUILD_DIR ?= obj_dir
FILELIST ?= sources.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/cache_tb.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_tb;

	localparam int TIMEOUT_CYCLES = 6 * 40 * 25;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_we;
	cache_pkg::addr_t req_addr;
	cache_pkg::strb_t req_strb;
	cache_pkg::word_t req_wdata;
	logic addr_ok;
	logic data_ok;
	cache_pkg::word_t rdata;
	logic mem_rd_req;
	cache_pkg::addr_t mem_rd_addr;
	logic mem_rd_valid;
	logic mem_rd_last;
	cache_pkg::word_t mem_rd_data;
	logic mem_wr_valid;
	cache_pkg::addr_t mem_wr_addr;
	cache_pkg::block_t mem_wr_data;
	logic mem_wr_ready;

	// backing memory and the expected view with all CPU writes applied
	cache_pkg::block_t mem_data [cache_pkg::addr_t];
	cache_pkg::block_t shadow [cache_pkg::addr_t];

	logic [31:0] lfsr_state = 32'd93447;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycles = 0;
	int wr_delay = 1;
	int rd_count = 0;
	int wr_count = 0;
	cache_pkg::addr_t last_rd_addr;
	cache_pkg::addr_t last_wr_addr;

	tb_clock #(.PERIOD(8)) tb_clock_i (.clk(clk));

	cache_top cache_top_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_we(req_we),
		.req_addr(req_addr),
		.req_strb(req_strb),
		.req_wdata(req_wdata),
		.addr_ok(addr_ok),
		.data_ok(data_ok),
		.rdata(rdata),
		.mem_rd_req(mem_rd_req),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_valid(mem_rd_valid),
		.mem_rd_last(mem_rd_last),
		.mem_rd_data(mem_rd_data),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data),
		.mem_wr_ready(mem_wr_ready)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic cache_pkg::word_t rand_word();
		cache_pkg::word_t v;
		v = '0;
		for (int i = 0; i < `CACHE_WORD_W; i++) begin
			v = {v[`CACHE_WORD_W-2:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic cache_pkg::addr_t make_addr(input cache_pkg::tag_t tag,
		input cache_pkg::index_t idx, input logic word);
		return {tag, idx, word, 3'b000};
	endfunction

	function automatic cache_pkg::addr_t block_of(input cache_pkg::addr_t a);
		return {a[31:4], 4'b0000};
	endfunction

	// block contents made on first touch
	function automatic void touch(input cache_pkg::addr_t a);
		cache_pkg::block_t v;
		if (!mem_data.exists(block_of(a))) begin
			v = {rand_word(), rand_word()};
			mem_data[block_of(a)] = v;
			shadow[block_of(a)] = v;
		end
	endfunction

	function automatic cache_pkg::word_t shadow_word(input cache_pkg::addr_t a);
		cache_pkg::block_t blk;
		blk = shadow[block_of(a)];
		return blk[int'(a[3]) * `CACHE_WORD_W +: `CACHE_WORD_W];
	endfunction

	function automatic void apply_write(input cache_pkg::addr_t a, input cache_pkg::strb_t strb,
		input cache_pkg::word_t data);
		cache_pkg::block_t blk;
		int base;
		blk = shadow[block_of(a)];
		base = int'(a[3]) * `CACHE_WORD_W;
		for (int i = 0; i < $bits(cache_pkg::strb_t); i++) begin
			if (strb[i]) begin
				blk[base + 8*i +: 8] = data[8*i +: 8];
			end
		end
		shadow[block_of(a)] = blk;
	endfunction

	task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t expected,
		input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_block(input cache_pkg::block_t got, input cache_pkg::block_t expected,
		input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_addr(input cache_pkg::addr_t got, input cache_pkg::addr_t expected,
		input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		if (cond !== 1'b1) begin
			errors++;
			$display("At %0t ns: %s", $time, what);
		end
	endtask

	// read beats, gaps follow the set index
	always begin : rd_model
		cache_pkg::addr_t blk_addr;
		cache_pkg::block_t blk;
		int gap;
		@(negedge clk);
		if (mem_rd_req) begin
			blk_addr = mem_rd_addr;
			rd_count++;
			last_rd_addr = blk_addr;
			touch(blk_addr);
			blk = mem_data[blk_addr];
			for (int b = 0; b < `CACHE_BEATS; b++) begin
				gap = (int'(blk_addr[7:4]) + b) % 3;
				repeat (b == 0 ? gap + 1 : gap) begin
					@(posedge clk);
					#1;
				end
				mem_rd_valid = 1'b1;
				mem_rd_last = (b == `CACHE_BEATS - 1);
				mem_rd_data = blk[b*`CACHE_WORD_W +: `CACHE_WORD_W];
				@(posedge clk);
				#1;
				mem_rd_valid = 1'b0;
				mem_rd_last = 1'b0;
			end
		end
	end

	// writeback, ready held low for wr_delay cycles
	always begin : wr_model
		cache_pkg::addr_t wb_addr;
		cache_pkg::block_t wb_data;
		@(negedge clk);
		if (mem_wr_valid) begin
			wb_addr = mem_wr_addr;
			wb_data = mem_wr_data;
			wr_count++;
			last_wr_addr = wb_addr;
			expect_true(shadow.exists(wb_addr), "writeback to a block the CPU never used");
			if (shadow.exists(wb_addr)) begin
				check_block(wb_data, shadow[wb_addr], "writeback data");
			end
			for (int i = 1; i < wr_delay; i++) begin
				@(negedge clk);
				expect_true(mem_wr_valid, "mem_wr_valid dropped before mem_wr_ready");
				check_addr(mem_wr_addr, wb_addr, "writeback address while stalled");
				check_block(mem_wr_data, wb_data, "writeback data while stalled");
			end
			@(posedge clk);
			#1;
			mem_wr_ready = 1'b1;
			@(posedge clk);
			#1;
			mem_wr_ready = 1'b0;
			mem_data[wb_addr] = wb_data;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// one request, returns read data and cycles from acceptance to data_ok
	task automatic cpu_access(input logic we, input cache_pkg::addr_t addr,
		input cache_pkg::strb_t strb, input cache_pkg::word_t wdata,
		output cache_pkg::word_t rd, output int lat);
		@(posedge clk);
		#1;
		touch(addr);
		req_valid = 1'b1;
		req_we = we;
		req_addr = addr;
		req_strb = strb;
		req_wdata = wdata;
		@(negedge clk);
		while (!addr_ok) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		@(negedge clk);
		lat = 1;
		while (!data_ok) begin
			@(negedge clk);
			lat++;
		end
		rd = rdata;
		if (we) begin
			apply_write(addr, strb, wdata);
		end
		@(negedge clk);
		expect_true(!data_ok, "data_ok stayed high for more than one cycle");
	endtask

	task automatic read_check(input cache_pkg::addr_t addr, output int lat);
		cache_pkg::word_t rd;
		cpu_access(1'b0, addr, '0, '0, rd, lat);
		check_word(rd, shadow_word(addr), "read data");
	endtask

	task automatic write_word(input cache_pkg::addr_t addr, input cache_pkg::strb_t strb,
		output int lat);
		cache_pkg::word_t rd;
		cpu_access(1'b1, addr, strb, rand_word(), rd, lat);
	endtask

	// req_valid held high, a new address after each acceptance
	task automatic burst_reads(input cache_pkg::addr_t addrs[$]);
		cache_pkg::word_t expq[$];
		int issued;
		int done;
		int cyc;
		int last_acc;
		issued = 0;
		done = 0;
		cyc = 0;
		last_acc = -1;
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		req_we = 1'b0;
		req_strb = '0;
		req_addr = addrs[0];
		while (done < addrs.size()) begin
			@(negedge clk);
			if (data_ok) begin
				expect_true(expq.size() > 0, "data_ok with no read outstanding");
				if (expq.size() > 0) begin
					check_word(rdata, expq.pop_front(), "back-to-back read data");
				end
				done++;
			end
			if (req_valid && addr_ok) begin
				if (last_acc >= 0) begin
					expect_true(cyc == last_acc + 1, "read hit not accepted on the next cycle");
				end
				last_acc = cyc;
				expq.push_back(shadow_word(addrs[issued]));
				issued++;
			end
			@(posedge clk);
			#1;
			cyc++;
			if (issued < addrs.size()) begin
				req_addr = addrs[issued];
			end else begin
				req_valid = 1'b0;
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		$display("test %0d, %s: %0d errors", tests_run, name, errors - err_before);
	endtask

	task automatic test_cold_read();
		int err0;
		int rd0;
		int lat;
		cache_pkg::addr_t a;
		err0 = errors;
		a = make_addr(24'h000101, 4'd1, 1'b1);
		rd0 = rd_count;
		read_check(a, lat);
		expect_true(rd_count == rd0 + 1, "cold read did not refill exactly once");
		check_addr(last_rd_addr, block_of(a), "refill address");
		read_check(a, lat);
		expect_true(rd_count == rd0 + 1, "second read went to memory");
		expect_true(lat == 1, "read hit took more than one cycle");
		report_test("cold read miss then hit", err0);
	endtask

	task automatic test_write_hit();
		int err0;
		int rd0;
		int wr0;
		int lat;
		cache_pkg::addr_t a;
		err0 = errors;
		a = make_addr(24'h000202, 4'd2, 1'b0);
		read_check(a, lat);
		rd0 = rd_count;
		wr0 = wr_count;
		write_word(a, 8'b0101_1010, lat);
		expect_true(lat == 1, "write hit took more than one cycle");
		read_check(a, lat);
		read_check(make_addr(24'h000202, 4'd2, 1'b1), lat);
		expect_true(rd_count == rd0 && wr_count == wr0, "memory traffic on write hits");
		report_test("write hit with strobes", err0);
	endtask

	task automatic test_write_miss();
		int err0;
		int rd0;
		int lat;
		err0 = errors;
		rd0 = rd_count;
		write_word(make_addr(24'h000303, 4'd3, 1'b1), 8'hf0, lat);
		expect_true(rd_count == rd0 + 1, "write miss did not refill exactly once");
		read_check(make_addr(24'h000303, 4'd3, 1'b0), lat);
		read_check(make_addr(24'h000303, 4'd3, 1'b1), lat);
		expect_true(rd_count == rd0 + 1, "read-back after write miss went to memory");
		report_test("write miss with merge", err0);
	endtask

	task automatic test_eviction();
		int err0;
		int wr0;
		int lat;
		err0 = errors;
		// way 0 dirty, then way 1 clean
		write_word(make_addr(24'h00a401, 4'd4, 1'b0), 8'hff, lat);
		read_check(make_addr(24'h00a402, 4'd4, 1'b1), lat);
		wr0 = wr_count;
		// victims go way 0, way 1, way 0
		write_word(make_addr(24'h00a403, 4'd4, 1'b1), 8'h0f, lat);
		expect_true(wr_count == wr0 + 1, "dirty victim in way 0 not written back");
		check_addr(last_wr_addr, make_addr(24'h00a401, 4'd4, 1'b0), "first victim address");
		read_check(make_addr(24'h00a404, 4'd4, 1'b0), lat);
		expect_true(wr_count == wr0 + 1, "clean victim in way 1 was written back");
		read_check(make_addr(24'h00a401, 4'd4, 1'b1), lat);
		expect_true(wr_count == wr0 + 2, "dirty victim in way 0 not written back");
		check_addr(last_wr_addr, make_addr(24'h00a403, 4'd4, 1'b0), "third victim address");
		report_test("dirty eviction", err0);
	endtask

	task automatic test_back_to_back();
		int err0;
		int rd0;
		int lat;
		cache_pkg::addr_t seq[$];
		err0 = errors;
		read_check(make_addr(24'h000501, 4'd5, 1'b0), lat);
		read_check(make_addr(24'h000502, 4'd5, 1'b0), lat);
		for (int i = 0; i < 8; i++) begin
			seq.push_back(make_addr(i[1] ? 24'h000502 : 24'h000501, 4'd5, i[0] ^ i[2]));
		end
		rd0 = rd_count;
		burst_reads(seq);
		expect_true(rd_count == rd0, "back-to-back read hits went to memory");
		report_test("back-to-back read hits", err0);
	endtask

	task automatic test_back_pressure();
		int err0;
		int wr0;
		int lat;
		err0 = errors;
		wr_delay = 10;
		write_word(make_addr(24'h000601, 4'd6, 1'b1), 8'h3c, lat);
		read_check(make_addr(24'h000602, 4'd6, 1'b0), lat);
		wr0 = wr_count;
		read_check(make_addr(24'h000603, 4'd6, 1'b1), lat);
		expect_true(wr_count == wr0 + 1, "stalled writeback not seen exactly once");
		check_addr(last_wr_addr, make_addr(24'h000601, 4'd6, 1'b0), "stalled victim address");
		expect_true(lat > 10, "miss finished before the writeback stall ended");
		wr_delay = 1;
		report_test("writeback back-pressure", err0);
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_we = 1'b0;
		req_addr = '0;
		req_strb = '0;
		req_wdata = '0;
		mem_rd_valid = 1'b0;
		mem_rd_last = 1'b0;
		mem_rd_data = '0;
		mem_wr_ready = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		expect_true(addr_ok && !data_ok && !mem_rd_req && !mem_wr_valid,
			"outputs not at their idle values after reset");
		test_cold_read();
		test_write_hit();
		test_write_miss();
		test_eviction();
		test_back_to_back();
		test_back_pressure();
		$display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	// free-running clock, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

endmodule

//--- hdl/cache_arrays.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_arrays (
	input logic clk,
	input logic rst,
	input logic rd_en,
	input cache_pkg::index_t rd_index,
	input logic wr_data_en,
	input cache_pkg::way_t wr_way,
	input logic wr_word,
	input cache_pkg::index_t wr_index,
	input cache_pkg::word_t wr_word_data,
	input logic wr_tag_en,
	input cache_pkg::tag_t wr_tag,
	input logic wr_dirty,
	output cache_pkg::tag_t way_tags [`CACHE_WAYS],
	output logic [`CACHE_WAYS-1:0] way_valid,
	output logic [`CACHE_WAYS-1:0] way_dirty,
	output cache_pkg::block_t way_blocks [`CACHE_WAYS]
);

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		logic way_sel;
		logic tag_we;
		logic dirty_we;
		logic [`CACHE_SETS-1:0] valid_bits;

		assign way_sel = (wr_way == cache_pkg::way_t'(w));
		assign tag_we = wr_tag_en && way_sel;
		// a data write or a tag write both update dirty
		assign dirty_we = (wr_data_en || wr_tag_en) && way_sel;

		for (genvar b = 0; b < `CACHE_BEATS; b++) begin : g_bank
			logic bank_we;

			assign bank_we = wr_data_en && way_sel && (wr_word == 1'(b));

			sp_ram #(
				.DATA_W(`CACHE_WORD_W),
				.DEPTH(`CACHE_SETS)
			) data_ram_i (
				.clk(clk),
				.cs(rd_en || bank_we),
				.we(bank_we),
				.addr(bank_we ? wr_index : rd_index),
				.din(wr_word_data),
				.dout(way_blocks[w][b*`CACHE_WORD_W +: `CACHE_WORD_W])
			);
		end

		sp_ram #(
			.DATA_W(`CACHE_TAG_W),
			.DEPTH(`CACHE_SETS)
		) tag_ram_i (
			.clk(clk),
			.cs(rd_en || tag_we),
			.we(tag_we),
			.addr(tag_we ? wr_index : rd_index),
			.din(wr_tag),
			.dout(way_tags[w])
		);

		sp_ram #(
			.DATA_W(1),
			.DEPTH(`CACHE_SETS)
		) dirty_ram_i (
			.clk(clk),
			.cs(rd_en || dirty_we),
			.we(dirty_we),
			.addr(dirty_we ? wr_index : rd_index),
			.din(wr_dirty),
			.dout(way_dirty[w])
		);

		// valid bits in flops so reset can clear them
		always_ff @(posedge clk) begin
			if (rst) begin
				valid_bits <= '0;
				way_valid[w] <= 1'b0;
			end else begin
				if (tag_we) begin
					valid_bits[wr_index] <= 1'b1;
				end
				if (rd_en) begin
					way_valid[w] <= valid_bits[rd_index];
				end
			end
		end
	end

	// single-port banks, lookup read and update never share a cycle
	assert property (@(posedge clk) disable iff (rst)
		!(rd_en && (wr_data_en || wr_tag_en)));

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_ctrl (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_we,
	input cache_pkg::addr_t req_addr,
	input cache_pkg::strb_t req_strb,
	input cache_pkg::word_t req_wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::word_t rdata,
	output logic mem_rd_req,
	output cache_pkg::addr_t mem_rd_addr,
	input logic mem_rd_valid,
	input logic mem_rd_last,
	input cache_pkg::word_t mem_rd_data,
	output logic mem_wr_valid,
	output cache_pkg::addr_t mem_wr_addr,
	output cache_pkg::block_t mem_wr_data,
	input logic mem_wr_ready,
	input logic hit,
	input cache_pkg::way_t hit_way,
	input cache_pkg::word_t hit_word,
	input cache_pkg::way_t victim_way,
	input logic victim_dirty,
	input cache_pkg::addr_t victim_addr,
	input cache_pkg::block_t victim_block,
	output logic capture,
	output logic refill_done,
	output cache_pkg::tag_t req_tag,
	output cache_pkg::index_t req_index,
	output logic req_word,
	output logic rd_en,
	output cache_pkg::index_t rd_index,
	output logic wr_data_en,
	output cache_pkg::way_t wr_way,
	output logic wr_word,
	output cache_pkg::index_t wr_index,
	output cache_pkg::word_t wr_word_data,
	output logic wr_tag_en,
	output cache_pkg::tag_t wr_tag,
	output logic wr_dirty
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t state_nxt;

	logic buf_we;
	cache_pkg::strb_t buf_strb;
	cache_pkg::word_t buf_wdata;
	logic accept;
	logic write_hit;
	logic refill_beat;
	logic [$clog2(`CACHE_BEATS)-1:0] beat_cnt;
	cache_pkg::word_t refill_word;
	cache_pkg::word_t resp_word;

	// strobed bytes of new_word laid over old_word
	function automatic cache_pkg::word_t merge_bytes(
		input cache_pkg::word_t old_word,
		input cache_pkg::word_t new_word,
		input cache_pkg::strb_t strb
	);
		cache_pkg::word_t merged;
		merged = old_word;
		for (int i = 0; i < $bits(cache_pkg::strb_t); i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return merged;
	endfunction

	assign addr_ok = (state == cache_pkg::S_IDLE) ||
		(state == cache_pkg::S_LOOKUP && hit && !buf_we);
	assign accept = req_valid && addr_ok;
	assign write_hit = (state == cache_pkg::S_LOOKUP) && hit && buf_we;
	assign refill_beat = (state == cache_pkg::S_REFILL) && mem_rd_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_pkg::S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			cache_pkg::S_IDLE: begin
				if (accept) begin
					state_nxt = cache_pkg::S_LOOKUP;
				end
			end
			cache_pkg::S_LOOKUP: begin
				// a read hit with a new request stays in lookup
				if (!hit) begin
					state_nxt = cache_pkg::S_MISS;
				end else if (!accept) begin
					state_nxt = cache_pkg::S_IDLE;
				end
			end
			cache_pkg::S_MISS: begin
				state_nxt = victim_dirty ? cache_pkg::S_REPLACE : cache_pkg::S_REFILL;
			end
			cache_pkg::S_REPLACE: begin
				if (mem_wr_ready) begin
					state_nxt = cache_pkg::S_REFILL;
				end
			end
			cache_pkg::S_REFILL: begin
				if (mem_rd_valid && mem_rd_last) begin
					state_nxt = cache_pkg::S_RESP;
				end
			end
			default: begin
				state_nxt = cache_pkg::S_IDLE;
			end
		endcase
	end

	// request buffer
	always_ff @(posedge clk) begin
		if (accept) begin
			buf_we <= req_we;
			req_tag <= req_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
			req_index <= req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
			req_word <= req_addr[`CACHE_OFFSET_W-1];
			buf_strb <= req_strb;
			buf_wdata <= req_wdata;
		end
	end

	// lookup reads with the incoming index
	assign rd_en = accept;
	assign rd_index = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

	// victim snapshot taken as lookup misses
	assign capture = (state == cache_pkg::S_LOOKUP) && !hit;

	always_ff @(posedge clk) begin
		if (rst || state != cache_pkg::S_REFILL) begin
			beat_cnt <= '0;
		end else if (mem_rd_valid) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign refill_word = (buf_we && beat_cnt == req_word) ?
		merge_bytes(mem_rd_data, buf_wdata, buf_strb) : mem_rd_data;
	assign refill_done = refill_beat && mem_rd_last;

	always_ff @(posedge clk) begin
		if (refill_beat && beat_cnt == req_word) begin
			resp_word <= refill_word;
		end
	end

	always_comb begin
		wr_data_en = 1'b0;
		wr_way = hit_way;
		wr_word = req_word;
		wr_index = req_index;
		wr_word_data = merge_bytes(hit_word, buf_wdata, buf_strb);
		wr_tag_en = 1'b0;
		wr_tag = req_tag;
		wr_dirty = 1'b1;
		if (write_hit) begin
			wr_data_en = 1'b1;
		end else if (refill_beat) begin
			wr_data_en = 1'b1;
			wr_way = victim_way;
			wr_word = beat_cnt;
			wr_word_data = refill_word;
			// tag goes in with the last beat
			wr_tag_en = mem_rd_last;
			wr_dirty = buf_we;
		end
	end

	assign data_ok = (state == cache_pkg::S_LOOKUP && hit) || (state == cache_pkg::S_RESP);
	assign rdata = (state == cache_pkg::S_LOOKUP) ? hit_word : resp_word;

	// memory ports
	assign mem_rd_req = (state == cache_pkg::S_REFILL);
	assign mem_rd_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
	assign mem_wr_valid = (state == cache_pkg::S_REPLACE);
	assign mem_wr_addr = victim_addr;
	assign mem_wr_data = victim_block;

	assert property (@(posedge clk) disable iff (rst)
		mem_wr_valid && !mem_wr_ready |=>
		mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data));

endmodule

//--- hdl/cache_lookup.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_lookup (
	input logic clk,
	input logic rst,
	input cache_pkg::tag_t req_tag,
	input cache_pkg::index_t req_index,
	input logic req_word,
	input cache_pkg::tag_t way_tags [`CACHE_WAYS],
	input logic [`CACHE_WAYS-1:0] way_valid,
	input logic [`CACHE_WAYS-1:0] way_dirty,
	input cache_pkg::block_t way_blocks [`CACHE_WAYS],
	input logic capture,
	input logic refill_done,
	output logic hit,
	output cache_pkg::way_t hit_way,
	output cache_pkg::word_t hit_word,
	output cache_pkg::way_t victim_way,
	output logic victim_dirty,
	output cache_pkg::addr_t victim_addr,
	output cache_pkg::block_t victim_block
);

	logic [`CACHE_WAYS-1:0] way_hit;
	cache_pkg::way_t rr_bits [`CACHE_SETS];
	cache_pkg::way_t victim_sel;

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_cmp
		assign way_hit[w] = way_valid[w] && (way_tags[w] == req_tag);
	end

	assign hit = |way_hit;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (way_hit[w]) begin
				hit_way = cache_pkg::way_t'(w);
			end
		end
	end

	assign hit_word = way_blocks[hit_way][req_word*`CACHE_WORD_W +: `CACHE_WORD_W];

	// round robin, one pointer per set
	assign victim_sel = rr_bits[req_index];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				rr_bits[s] <= '0;
			end
			victim_dirty <= 1'b0;
		end else begin
			if (refill_done) begin
				rr_bits[req_index] <= rr_bits[req_index] + 1'b1;
			end
			if (capture) begin
				victim_dirty <= way_valid[victim_sel] && way_dirty[victim_sel];
			end
		end
	end

	// victim line snapshot for writeback
	always_ff @(posedge clk) begin
		if (capture) begin
			victim_way <= victim_sel;
			victim_addr <= {way_tags[victim_sel], req_index, {`CACHE_OFFSET_W{1'b0}}};
			victim_block <= way_blocks[victim_sel];
		end
	end

	// a tag is never resident in two ways of one set
	assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

//--- hdl/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// one strobe per byte lane
	typedef logic [`CACHE_WORD_W/8-1:0] strb_t;

	// word 0 sits in the low half
	typedef logic [`CACHE_BEATS*`CACHE_WORD_W-1:0] block_t;

	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

	// main controller FSM
	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_MISS,
		S_REPLACE,
		S_REFILL,
		S_RESP
	} ctrl_state_t;

endpackage

//--- hdl/cache_top.sv
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_top (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_we,
	input cache_pkg::addr_t req_addr,
	input cache_pkg::strb_t req_strb,
	input cache_pkg::word_t req_wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::word_t rdata,
	output logic mem_rd_req,
	output cache_pkg::addr_t mem_rd_addr,
	input logic mem_rd_valid,
	input logic mem_rd_last,
	input cache_pkg::word_t mem_rd_data,
	output logic mem_wr_valid,
	output cache_pkg::addr_t mem_wr_addr,
	output cache_pkg::block_t mem_wr_data,
	input logic mem_wr_ready
);

	// lookup results
	logic hit;
	cache_pkg::way_t hit_way;
	cache_pkg::word_t hit_word;
	cache_pkg::way_t victim_way;
	logic victim_dirty;
	cache_pkg::addr_t victim_addr;
	cache_pkg::block_t victim_block;
	logic capture;
	logic refill_done;
	cache_pkg::tag_t req_tag;
	cache_pkg::index_t req_index;
	logic req_word;

	// array access
	logic rd_en;
	cache_pkg::index_t rd_index;
	logic wr_data_en;
	cache_pkg::way_t wr_way;
	logic wr_word;
	cache_pkg::index_t wr_index;
	cache_pkg::word_t wr_word_data;
	logic wr_tag_en;
	cache_pkg::tag_t wr_tag;
	logic wr_dirty;
	cache_pkg::tag_t way_tags [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] way_valid;
	logic [`CACHE_WAYS-1:0] way_dirty;
	cache_pkg::block_t way_blocks [`CACHE_WAYS];

	cache_ctrl cache_ctrl_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_we(req_we),
		.req_addr(req_addr),
		.req_strb(req_strb),
		.req_wdata(req_wdata),
		.addr_ok(addr_ok),
		.data_ok(data_ok),
		.rdata(rdata),
		.mem_rd_req(mem_rd_req),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_valid(mem_rd_valid),
		.mem_rd_last(mem_rd_last),
		.mem_rd_data(mem_rd_data),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data),
		.mem_wr_ready(mem_wr_ready),
		.hit(hit),
		.hit_way(hit_way),
		.hit_word(hit_word),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_block(victim_block),
		.capture(capture),
		.refill_done(refill_done),
		.req_tag(req_tag),
		.req_index(req_index),
		.req_word(req_word),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.wr_data_en(wr_data_en),
		.wr_way(wr_way),
		.wr_word(wr_word),
		.wr_index(wr_index),
		.wr_word_data(wr_word_data),
		.wr_tag_en(wr_tag_en),
		.wr_tag(wr_tag),
		.wr_dirty(wr_dirty)
	);

	cache_lookup cache_lookup_i (
		.clk(clk),
		.rst(rst),
		.req_tag(req_tag),
		.req_index(req_index),
		.req_word(req_word),
		.way_tags(way_tags),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.way_blocks(way_blocks),
		.capture(capture),
		.refill_done(refill_done),
		.hit(hit),
		.hit_way(hit_way),
		.hit_word(hit_word),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_block(victim_block)
	);

	cache_arrays cache_arrays_i (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.wr_data_en(wr_data_en),
		.wr_way(wr_way),
		.wr_word(wr_word),
		.wr_index(wr_index),
		.wr_word_data(wr_word_data),
		.wr_tag_en(wr_tag_en),
		.wr_tag(wr_tag),
		.wr_dirty(wr_dirty),
		.way_tags(way_tags),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.way_blocks(way_blocks)
	);

endmodule

//--- hdl/sp_ram.sv
`timescale 1ns/1ns

module sp_ram #(
	parameter int DATA_W = 64,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic cs,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] addr,
	input logic [DATA_W-1:0] din,
	output logic [DATA_W-1:0] dout
);

	logic [DATA_W-1:0] mem [DEPTH];

	// read data registered, held while not selected or on a write
	always_ff @(posedge clk) begin
		if (cs) begin
			if (we) begin
				mem[addr] <= din;
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_WAYS 2
`define CACHE_SETS 16

// address split: tag, index, byte offset
`define CACHE_INDEX_W 4
`define CACHE_OFFSET_W 4
`define CACHE_TAG_W 24
`define CACHE_ADDR_W 32

// data path, a block holds CACHE_BEATS words
`define CACHE_WORD_W 64
`define CACHE_BEATS 2

`endif

//--- sources.f
+incdir+include
hdl/cache_pkg.sv
hdl/sp_ram.sv
hdl/cache_arrays.sv
hdl/cache_lookup.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
dv/tb_clock.sv
dv/cache_tb.sv
